//--- robTop.f
uopPkg.sv
robPkg.sv
robReadIf.sv
robStorage.sv
robReplay.sv
robCommit.sv
robTop.sv
tbClock.sv
robTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= robTb
FILELIST ?= robTop.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- robTb.sv
`timescale 1ns/100ps

module robTb;

  localparam int cycleLimit = 2000;
  localparam int randomOps = 160;
  localparam int tailOps = 40;

  logic clk;
  logic rst;
  logic enqValid [robPkg::robWidth];
  robPkg::SqN enqSqN [robPkg::robWidth];
  robPkg::RegNm enqRd [robPkg::robWidth];
  robPkg::Tag enqTag [robPkg::robWidth];
  uopPkg::OpKind enqKind [robPkg::robWidth];
  logic flagValid [robPkg::numFlagPorts];
  robPkg::SqN flagSqN [robPkg::numFlagPorts];
  uopPkg::RobFlags flagFlags [robPkg::numFlagPorts];
  logic branchTaken;
  robPkg::SqN branchSqN;
  logic comValid [robPkg::robWidth];
  robPkg::SqN comSqN [robPkg::robWidth];
  robPkg::RegNm comRd [robPkg::robWidth];
  robPkg::Tag comTag [robPkg::robWidth];
  logic trapValid;
  robPkg::SqN trapSqN;
  uopPkg::RobFlags trapFlags;
  robPkg::RegNm trapRd;
  logic mispredFlush;
  robPkg::SqN curSqN;
  robPkg::SqN maxSqN;

  // Model of every op, indexed by its full sequence number
  robPkg::RegNm modelRd [64];
  robPkg::Tag modelTag [64];
  uopPkg::RobFlags modelFlags [64];
  logic ready [64];
  logic alive [64];
  robPkg::RegNm replayRdExp [64];
  robPkg::Tag replayTagExp [64];
  robPkg::SqN pending [$];
  robPkg::SqN nextCom;
  robPkg::SqN nextEnq;
  int replayPtr;
  int replayLen;
  int unsigned seed = 32'he713_3bab;
  int valueErrors = 0;
  int ruleErrors = 0;
  int committed = 0;
  int cycles = 0;

  // Expected view of the next four lanes
  robPkg::SqN wantSqN [robPkg::robWidth];
  uopPkg::RobFlags wantFlags [robPkg::robWidth];
  robPkg::RegNm wantRd [robPkg::robWidth];
  robPkg::Tag wantTag [robPkg::robWidth];
  robPkg::RegNm wantTrapRd [robPkg::robWidth];
  logic wantOk [robPkg::robWidth];
  logic wantTrap [robPkg::robWidth];
  robPkg::RegNm repRd [robPkg::robWidth];
  robPkg::Tag repTag [robPkg::robWidth];
  logic repInRange [robPkg::robWidth];

  tbClock i_clock (.clk(clk), .rst(rst));
  robTop i_dut (.*);

  function automatic int unsigned lcg(int unsigned range);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return (seed >> 8) % range;
  endfunction

  // Fence, decode traps and the two exceptions all stop commit
  function automatic logic trapNeeded(uopPkg::RobFlags f);
    return f inside {uopPkg::FLAGS_FENCE, uopPkg::FLAGS_TRAP, uopPkg::FLAGS_ILLEGAL,
                     uopPkg::FLAGS_LD_MISALIGN};
  endfunction

  function automatic logic writesZero(uopPkg::RobFlags f);
    return f inside {uopPkg::FLAGS_ILLEGAL, uopPkg::FLAGS_LD_MISALIGN};
  endfunction

  function automatic uopPkg::RobFlags pickFlags();
    case (lcg(16))
      0: return uopPkg::FLAGS_FENCE;
      1: return uopPkg::FLAGS_ILLEGAL;
      2: return uopPkg::FLAGS_LD_MISALIGN;
      3, 4, 5: return uopPkg::FLAGS_BRANCH;
      default: return uopPkg::FLAGS_NONE;
    endcase
  endfunction

  // Free slots up to maxSqN within one group
  function automatic int room();
    int k;
    k = 0;
    while (k < robPkg::robWidth &&
           $signed(robPkg::SqN'(nextEnq + robPkg::SqN'(k) - maxSqN)) <= 0) begin
      k++;
    end
    return k;
  endfunction

  task automatic valueError(string name, int got, int want);
    valueErrors++;
    $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
  endtask

  task automatic ruleError(string what);
    ruleErrors++;
    $display("Check failed at %0t: %s", $time, what);
  endtask

  task automatic clearInputs();
    for (int i = 0; i < robPkg::robWidth; i++) begin
      enqValid[i] = 1'b0;
      enqSqN[i] = '0;
      enqRd[i] = '0;
      enqTag[i] = '0;
      enqKind[i] = uopPkg::KIND_EXEC;
    end
    for (int p = 0; p < robPkg::numFlagPorts; p++) begin
      flagValid[p] = 1'b0;
      flagSqN[p] = '0;
      flagFlags[p] = uopPkg::FLAGS_NONE;
    end
    branchTaken = 1'b0;
    branchSqN = '0;
  endtask

  // Lanes are filled in a rotated order
  task automatic enqueueOps(int n, bit mixKinds);
    int lane;
    int rot;
    int unsigned r;
    uopPkg::OpKind kind;
    rot = int'(lcg(robPkg::robWidth));
    for (int k = 0; k < n; k++) begin
      lane = (k + rot) % robPkg::robWidth;
      r = mixKinds ? lcg(10) : 9;
      kind = (r == 0) ? uopPkg::KIND_TRAP :
             (r < 3) ? uopPkg::KIND_RENAME_ONLY : uopPkg::KIND_EXEC;
      enqValid[lane] = 1'b1;
      enqSqN[lane] = nextEnq;
      enqRd[lane] = robPkg::RegNm'(lcg(32));
      enqTag[lane] = robPkg::Tag'(lcg(128));
      enqKind[lane] = kind;
      modelRd[nextEnq] = enqRd[lane];
      modelTag[nextEnq] = enqTag[lane];
      alive[nextEnq] = 1'b1;
      ready[nextEnq] = kind != uopPkg::KIND_EXEC;
      modelFlags[nextEnq] = (kind == uopPkg::KIND_RENAME_ONLY) ? uopPkg::FLAGS_NONE :
                            (kind == uopPkg::KIND_TRAP) ? uopPkg::FLAGS_TRAP :
                            uopPkg::FLAGS_NX;
      if (kind == uopPkg::KIND_EXEC) begin
        pending.push_back(nextEnq);
      end
      nextEnq++;
    end
  endtask

  // Random pick from ops enqueued in earlier cycles
  task automatic completeSome();
    int idx;
    robPkg::SqN s;
    uopPkg::RobFlags f;
    for (int p = 0; p < robPkg::numFlagPorts; p++) begin
      if (pending.size() > 0 && lcg(4) != 0) begin
        idx = int'(lcg(pending.size()));
        s = pending[idx];
        pending.delete(idx);
        f = pickFlags();
        flagValid[p] = 1'b1;
        flagSqN[p] = s;
        flagFlags[p] = f;
        modelFlags[s] = f;
        ready[s] = 1'b1;
      end
    end
  endtask

  task automatic runRandom(int ops);
    int sent;
    int n;
    sent = 0;
    while (sent < ops || pending.size() > 0) begin
      @(negedge clk);
      clearInputs();
      completeSome();
      n = int'(lcg(robPkg::robWidth + 1));
      n = (n > ops - sent) ? ops - sent : n;
      n = (n > room()) ? room() : n;
      enqueueOps(n, 1'b1);
      sent += n;
    end
    @(negedge clk);
    clearInputs();
    while (nextCom != nextEnq) @(negedge clk);
  endtask

  always_comb begin
    for (int i = 0; i < robPkg::robWidth; i++) begin
      wantSqN[i] = nextCom + robPkg::SqN'(i);
      wantFlags[i] = modelFlags[wantSqN[i]];
      wantOk[i] = ready[wantSqN[i]] && alive[wantSqN[i]];
      wantTrap[i] = trapNeeded(wantFlags[i]);
      wantRd[i] = writesZero(wantFlags[i]) ? '0 : modelRd[wantSqN[i]];
      wantTag[i] = writesZero(wantFlags[i]) ? '0 : modelTag[wantSqN[i]];
      wantTrapRd[i] = modelRd[wantSqN[i]];
      repRd[i] = replayRdExp[(replayPtr + i) % 64];
      repTag[i] = replayTagExp[(replayPtr + i) % 64];
      repInRange[i] = replayPtr + i < replayLen;
    end
  end

  // Commit and replay pointers follow the lanes seen at each edge
  always @(posedge clk) begin : trackCommit
    int cnt;
    cnt = 0;
    for (int i = 0; i < robPkg::robWidth; i++) begin
      cnt += comValid[i] ? 1 : 0;
    end
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout after %0d cycles, the ROB stopped making progress", cycles);
      $display("TB FAILED");
      $finish;
    end else if (rst) begin
      nextCom <= '0;
      replayPtr <= 0;
    end else if (mispredFlush) begin
      replayPtr <= replayPtr + cnt;
    end else begin
      nextCom <= nextCom + robPkg::SqN'(cnt);
      committed <= committed + cnt;
    end
  end

  for (genvar i = 0; i < robPkg::robWidth; i++) begin : laneChecks
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && !mispredFlush |-> comSqN[i] == wantSqN[i])
      else valueError($sformatf("comSqN[%0d]", i), int'($sampled(comSqN[i])),
                      int'($sampled(wantSqN[i])));
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && !mispredFlush |-> comRd[i] == wantRd[i])
      else valueError($sformatf("comRd[%0d]", i), int'($sampled(comRd[i])),
                      int'($sampled(wantRd[i])));
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && !mispredFlush |-> comTag[i] == wantTag[i])
      else valueError($sformatf("comTag[%0d]", i), int'($sampled(comTag[i])),
                      int'($sampled(wantTag[i])));
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && !mispredFlush |-> wantOk[i])
      else ruleError($sformatf("lane %0d committed an op that was not done", i));
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && !mispredFlush && wantTrap[i] |-> trapValid)
      else ruleError($sformatf("lane %0d committed a trap op without trapValid", i));
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && !mispredFlush && wantTrap[i] |-> trapSqN == wantSqN[i])
      else valueError("trapSqN", int'($sampled(trapSqN)), int'($sampled(wantSqN[i])));
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && !mispredFlush && wantTrap[i] |-> trapFlags == wantFlags[i])
      else valueError("trapFlags", int'($sampled(trapFlags)), int'($sampled(wantFlags[i])));
    // The trap port keeps the destination of the trapping op
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && !mispredFlush && wantTrap[i] |-> trapRd == wantTrapRd[i])
      else valueError("trapRd", int'($sampled(trapRd)), int'($sampled(wantTrapRd[i])));
    // Replay lanes against the list taken when the branch resolved
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && mispredFlush |-> comRd[i] == repRd[i])
      else valueError($sformatf("comRd[%0d]", i), int'($sampled(comRd[i])),
                      int'($sampled(repRd[i])));
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && mispredFlush |-> comTag[i] == repTag[i])
      else valueError($sformatf("comTag[%0d]", i), int'($sampled(comTag[i])),
                      int'($sampled(repTag[i])));
    assert property (@(posedge clk) disable iff (rst)
      comValid[i] && mispredFlush |-> repInRange[i])
      else ruleError($sformatf("replay lane %0d runs past the branch", i));
    if (i > 0) begin : prefixChk
      assert property (@(posedge clk) disable iff (rst) comValid[i] |-> comValid[i-1])
        else ruleError($sformatf("lane %0d valid after an idle lane", i));
    end
    if (i < robPkg::robWidth - 1) begin : blockChk
      assert property (@(posedge clk) disable iff (rst)
        comValid[i] && !mispredFlush && wantTrap[i] |-> !comValid[i+1])
        else ruleError($sformatf("lane %0d committed behind a trap", i + 1));
    end
  end

  assert property (@(posedge clk)
    $fell(rst) |-> !(comValid[0] || comValid[1] || comValid[2] || comValid[3]) &&
                   !trapValid && !mispredFlush && curSqN == 0 && maxSqN == 15)
    else ruleError("outputs not idle after reset");

  assert property (@(posedge clk) disable iff (rst) $past(trapValid) |-> !comValid[0])
    else ruleError("commit in the cycle after a trap");

  assert property (@(posedge clk) disable iff (rst) $fell(mispredFlush) |-> replayPtr == replayLen)
    else ruleError("replay ended before reaching the branch");

  initial begin : stimulus
    robPkg::SqN first;
    robPkg::SqN brSqN;
    robPkg::SqN s;
    int k;
    clearInputs();
    nextEnq = '0;
    replayLen = 0;
    for (int j = 0; j < 64; j++) begin
      ready[j] = 1'b0;
      alive[j] = 1'b0;
      modelFlags[j] = uopPkg::FLAGS_NX;
    end
    @(negedge clk);
    while (rst) @(negedge clk);

    runRandom(randomOps);

    // Oldest op stays unexecuted, so nothing retires before the branch
    @(negedge clk);
    clearInputs();
    enqueueOps(4, 1'b0);
    @(negedge clk);
    clearInputs();
    enqueueOps(4, 1'b0);
    first = pending[0];
    pending.delete(0);
    // One decode-time trap inside the replayed range
    s = first + robPkg::SqN'(4);
    for (int i = 0; i < robPkg::robWidth; i++) begin
      if (enqValid[i] && enqSqN[i] == s) begin
        enqKind[i] = uopPkg::KIND_TRAP;
      end
    end
    modelFlags[s] = uopPkg::FLAGS_TRAP;
    ready[s] = 1'b1;
    for (int j = pending.size() - 1; j >= 0; j--) begin
      if (pending[j] == s) begin
        pending.delete(j);
      end
    end
    while (pending.size() > 0) begin
      @(negedge clk);
      clearInputs();
      completeSome();
    end
    @(negedge clk);
    clearInputs();
    brSqN = first + robPkg::SqN'(5);
    branchTaken = 1'b1;
    branchSqN = brSqN;
    s = nextCom;
    k = 0;
    while (s != robPkg::SqN'(brSqN + robPkg::SqN'(1))) begin
      replayRdExp[(replayPtr + k) % 64] = (modelFlags[s] == uopPkg::FLAGS_TRAP) ? '0 : modelRd[s];
      replayTagExp[(replayPtr + k) % 64] = modelTag[s];
      s++;
      k++;
    end
    replayLen = replayPtr + k;
    // Ops younger than the branch are gone
    while (s != nextEnq) begin
      alive[s] = 1'b0;
      s++;
    end
    nextEnq = brSqN + robPkg::SqN'(1);
    @(negedge clk);
    clearInputs();
    while (replayPtr != replayLen) @(negedge clk);

    // Release the stuck op, then refill over the squashed slots
    pending.push_back(first);
    while (pending.size() > 0) begin
      @(negedge clk);
      clearInputs();
      completeSome();
    end
    runRandom(tailOps);

    @(negedge clk);
    $display("Errors: %0d value, %0d other; %0d ops committed, %0d lanes replayed, %0d cycles",
             valueErrors, ruleErrors, committed, replayPtr, cycles);
    if (valueErrors + ruleErrors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tbClock.sv
`timescale 1ns/100ps

module tbClock (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held for four rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- robTop.sv
`timescale 1ns/100ps

module robTop (
  input  logic            clk,
  input  logic            rst,
  input  logic            enqValid [robPkg::robWidth],
  input  robPkg::SqN      enqSqN [robPkg::robWidth],
  input  robPkg::RegNm    enqRd [robPkg::robWidth],
  input  robPkg::Tag      enqTag [robPkg::robWidth],
  input  uopPkg::OpKind   enqKind [robPkg::robWidth],
  input  logic            flagValid [robPkg::numFlagPorts],
  input  robPkg::SqN      flagSqN [robPkg::numFlagPorts],
  input  uopPkg::RobFlags flagFlags [robPkg::numFlagPorts],
  input  logic            branchTaken,
  input  robPkg::SqN      branchSqN,
  output logic            comValid [robPkg::robWidth],
  output robPkg::SqN      comSqN [robPkg::robWidth],
  output robPkg::RegNm    comRd [robPkg::robWidth],
  output robPkg::Tag      comTag [robPkg::robWidth],
  output logic            trapValid,
  output robPkg::SqN      trapSqN,
  output uopPkg::RobFlags trapFlags,
  output robPkg::RegNm    trapRd,
  output logic            mispredFlush,
  output robPkg::SqN      curSqN,
  output robPkg::SqN      maxSqN
);

  logic replayActive;
  logic replayValid [robPkg::robWidth];
  robPkg::RegNm replayRd [robPkg::robWidth];
  robPkg::Tag replayTag [robPkg::robWidth];
  logic commitValid [robPkg::robWidth];
  robPkg::RegNm commitRd [robPkg::robWidth];
  robPkg::Tag commitTag [robPkg::robWidth];

  robReadIf rdStore ();
  robReadIf rdReplay ();
  robReadIf rdCommit ();

  // Replay owns the read lanes while it walks back to the branch
  assign rdStore.readBase = replayActive ? rdReplay.readBase : rdCommit.readBase;
  assign rdReplay.entry = rdStore.entry;
  assign rdReplay.flags = rdStore.flags;
  assign rdCommit.entry = rdStore.entry;
  assign rdCommit.flags = rdStore.flags;

  robStorage i_storage (
    .clk(clk), .rst(rst),
    .enqValid(enqValid), .enqSqN(enqSqN), .enqRd(enqRd), .enqTag(enqTag),
    .enqKind(enqKind),
    .flagValid(flagValid), .flagSqN(flagSqN), .flagFlags(flagFlags),
    .branchTaken(branchTaken), .branchSqN(branchSqN),
    .rd(rdStore.storage)
  );

  robReplay i_replay (
    .clk(clk), .rst(rst),
    .branchTaken(branchTaken), .branchSqN(branchSqN), .curSqN(curSqN),
    .rd(rdReplay.reader),
    .replayActive(replayActive),
    .replayValid(replayValid), .replayRd(replayRd), .replayTag(replayTag),
    .mispredFlush(mispredFlush)
  );

  robCommit i_commit (
    .clk(clk), .rst(rst),
    .replayActive(replayActive),
    .enqValid(enqValid), .enqSqN(enqSqN),
    .branchTaken(branchTaken), .branchSqN(branchSqN),
    .rd(rdCommit.reader),
    .curSqN(curSqN), .maxSqN(maxSqN),
    .comValid(commitValid), .comSqN(comSqN), .comRd(commitRd), .comTag(commitTag),
    .trapValid(trapValid), .trapSqN(trapSqN), .trapFlags(trapFlags), .trapRd(trapRd)
  );

  // Replay lanes share the commit outputs, marked by the flush strobe
  always_comb begin
    for (int i = 0; i < robPkg::robWidth; i++) begin
      comValid[i] = mispredFlush ? replayValid[i] : commitValid[i];
      comRd[i] = mispredFlush ? replayRd[i] : commitRd[i];
      comTag[i] = mispredFlush ? replayTag[i] : commitTag[i];
    end
  end

endmodule

//--- robCommit.sv
`timescale 1ns/100ps

module robCommit (
  input  logic            clk,
  input  logic            rst,
  input  logic            replayActive,
  input  logic            enqValid [robPkg::robWidth],
  input  robPkg::SqN      enqSqN [robPkg::robWidth],
  input  logic            branchTaken,
  input  robPkg::SqN      branchSqN,
  robReadIf.reader        rd,
  output robPkg::SqN      curSqN,
  output robPkg::SqN      maxSqN,
  output logic            comValid [robPkg::robWidth],
  output robPkg::SqN      comSqN [robPkg::robWidth],
  output robPkg::RegNm    comRd [robPkg::robWidth],
  output robPkg::Tag      comTag [robPkg::robWidth],
  output logic            trapValid,
  output robPkg::SqN      trapSqN,
  output uopPkg::RobFlags trapFlags,
  output robPkg::RegNm    trapRd
);

  // Oldest entry and one past the youngest renamed entry
  robPkg::SqN baseSqN;
  robPkg::SqN lastSqN;
  logic stop;

  logic [robPkg::robWidth-1:0] laneCommit;
  robPkg::SqN commitCnt;
  logic trapHit;
  logic [$clog2(robPkg::robWidth)-1:0] trapLane;
  robPkg::SqN enqLast;

  assign rd.readBase = baseSqN;
  assign curSqN = baseSqN;
  assign maxSqN = baseSqN + robPkg::SqN'(robPkg::robLength - 1);

  // Take the oldest contiguous run of executed ops, cut after a trap
  always_comb begin : selectBlk
    logic blocked;
    logic renamed;
    logic executed;
    blocked = replayActive || stop;
    commitCnt = '0;
    trapHit = 1'b0;
    trapLane = '0;
    for (int i = 0; i < robPkg::robWidth; i++) begin
      renamed = $signed(robPkg::SqN'(lastSqN - baseSqN)) > i;
      executed = rd.flags[i] != uopPkg::FLAGS_NX;
      laneCommit[i] = !blocked && renamed && executed;
      if (laneCommit[i]) begin
        commitCnt = commitCnt + 1'b1;
        if (uopPkg::needsTrap(rd.flags[i])) begin
          trapHit = 1'b1;
          trapLane = i[$clog2(robPkg::robWidth)-1:0];
          blocked = 1'b1;
        end
      end else begin
        blocked = 1'b1;
      end
    end
  end

  // Lanes may arrive in any order, so track the youngest
  always_comb begin
    enqLast = lastSqN;
    for (int i = 0; i < robPkg::robWidth; i++) begin
      if (enqValid[i] && $signed(robPkg::SqN'(enqSqN[i] + 1'b1 - enqLast)) > 0) begin
        enqLast = enqSqN[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      baseSqN <= '0;
      lastSqN <= '0;
      stop <= 1'b0;
      trapValid <= 1'b0;
      for (int i = 0; i < robPkg::robWidth; i++) begin
        comValid[i] <= 1'b0;
      end
    end else begin
      baseSqN <= baseSqN + commitCnt;
      stop <= trapHit;
      trapValid <= trapHit;
      for (int i = 0; i < robPkg::robWidth; i++) begin
        comValid[i] <= laneCommit[i];
      end
      // A taken branch cuts the buffer back and ignores enqueue
      if (branchTaken) begin
        lastSqN <= branchSqN + 1'b1;
      end else begin
        lastSqN <= enqLast;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < robPkg::robWidth; i++) begin
      comSqN[i] <= baseSqN + robPkg::SqN'(i);
      // Exceptions write their result to x0
      if (uopPkg::isException(rd.flags[i])) begin
        comRd[i] <= '0;
        comTag[i] <= robPkg::tagZero;
      end else begin
        comRd[i] <= rd.entry[i].rd;
        comTag[i] <= rd.entry[i].tag;
      end
    end
    trapSqN <= baseSqN + robPkg::SqN'(trapLane);
    trapFlags <= rd.flags[trapLane];
    trapRd <= rd.entry[trapLane].rd;
  end

endmodule

//--- robReplay.sv
`timescale 1ns/100ps

module robReplay (
  input  logic         clk,
  input  logic         rst,
  input  logic         branchTaken,
  input  robPkg::SqN   branchSqN,
  input  robPkg::SqN   curSqN,
  robReadIf.reader     rd,
  output logic         replayActive,
  output logic         replayValid [robPkg::robWidth],
  output robPkg::RegNm replayRd [robPkg::robWidth],
  output robPkg::Tag   replayTag [robPkg::robWidth],
  output logic         mispredFlush
);

  robPkg::SqN endSqN;
  robPkg::SqN iterSqN;
  logic busy;

  robPkg::SqN endNext;
  robPkg::SqN iterNext;
  robPkg::SqN laneSqN [robPkg::robWidth];
  logic [robPkg::robWidth-1:0] fwdMask;
  logic replayEnd;

  // A taken branch restarts the walk from the oldest entry
  always_comb begin
    if (branchTaken) begin
      endNext = branchSqN;
      iterNext = curSqN;
    end else begin
      endNext = endSqN;
      iterNext = iterSqN;
    end
  end

  assign replayActive = branchTaken || busy;
  assign rd.readBase = iterNext;

  // Forward only lanes at or before the branch
  always_comb begin
    for (int i = 0; i < robPkg::robWidth; i++) begin
      laneSqN[i] = iterNext + robPkg::SqN'(i);
      fwdMask[i] = $signed(robPkg::SqN'(laneSqN[i] - endNext)) <= 0;
    end
    replayEnd = !fwdMask[robPkg::robWidth-1] || (laneSqN[robPkg::robWidth-1] == endNext);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (replayActive) begin
      busy <= !replayEnd;
    end
  end

  always_ff @(posedge clk) begin
    if (replayActive) begin
      endSqN <= endNext;
      iterSqN <= iterNext + robPkg::SqN'(robPkg::robWidth);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mispredFlush <= 1'b0;
      for (int i = 0; i < robPkg::robWidth; i++) begin
        replayValid[i] <= 1'b0;
      end
    end else begin
      mispredFlush <= replayActive && (|fwdMask);
      for (int i = 0; i < robPkg::robWidth; i++) begin
        replayValid[i] <= replayActive && fwdMask[i];
      end
    end
  end

  // Decode-time traps never wrote a destination
  always_ff @(posedge clk) begin
    for (int i = 0; i < robPkg::robWidth; i++) begin
      replayRd[i] <= (rd.flags[i] == uopPkg::FLAGS_TRAP) ? '0 : rd.entry[i].rd;
      replayTag[i] <= rd.entry[i].tag;
    end
  end

endmodule

//--- robStorage.sv
`timescale 1ns/100ps

module robStorage (
  input  logic            clk,
  input  logic            rst,
  input  logic            enqValid [robPkg::robWidth],
  input  robPkg::SqN      enqSqN [robPkg::robWidth],
  input  robPkg::RegNm    enqRd [robPkg::robWidth],
  input  robPkg::Tag      enqTag [robPkg::robWidth],
  input  uopPkg::OpKind   enqKind [robPkg::robWidth],
  input  logic            flagValid [robPkg::numFlagPorts],
  input  robPkg::SqN      flagSqN [robPkg::numFlagPorts],
  input  uopPkg::RobFlags flagFlags [robPkg::numFlagPorts],
  input  logic            branchTaken,
  input  robPkg::SqN      branchSqN,
  robReadIf.storage       rd
);

  // Entries are written in order by rename, flags out of order by execution
  robPkg::RobEntry entries [robPkg::robLength];
  uopPkg::RobFlags flags [robPkg::robLength];

  logic flagKeep [robPkg::numFlagPorts];
  robPkg::RobIdx readIdx [robPkg::robWidth];

  function automatic uopPkg::RobFlags initFlags(uopPkg::OpKind kind);
    case (kind)
      uopPkg::KIND_RENAME_ONLY: initFlags = uopPkg::FLAGS_NONE;
      uopPkg::KIND_TRAP:        initFlags = uopPkg::FLAGS_TRAP;
      default:                  initFlags = uopPkg::FLAGS_NX;
    endcase
  endfunction

  // Drop completions of ops younger than a branch taken this cycle
  always_comb begin
    for (int i = 0; i < robPkg::numFlagPorts; i++) begin
      flagKeep[i] = flagValid[i] &&
        (!branchTaken || $signed(robPkg::SqN'(flagSqN[i] - branchSqN)) <= 0);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < robPkg::robWidth; i++) begin
      if (enqValid[i] && !branchTaken) begin
        entries[enqSqN[i][robPkg::idLen-1:0]] <= '{tag: enqTag[i], rd: enqRd[i]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < robPkg::robLength; i++) begin
        flags[i] <= uopPkg::FLAGS_NX;
      end
    end else begin
      for (int i = 0; i < robPkg::robWidth; i++) begin
        if (enqValid[i] && !branchTaken) begin
          flags[enqSqN[i][robPkg::idLen-1:0]] <= initFlags(enqKind[i]);
        end
      end
      // Completion wins over enqueue on the same slot
      for (int i = 0; i < robPkg::numFlagPorts; i++) begin
        if (flagKeep[i]) begin
          flags[flagSqN[i][robPkg::idLen-1:0]] <= flagFlags[i];
        end
      end
    end
  end

  // Read lanes wrap around the end of the buffer
  always_comb begin
    for (int i = 0; i < robPkg::robWidth; i++) begin
      readIdx[i] = rd.readBase[robPkg::idLen-1:0] + robPkg::RobIdx'(i);
      rd.entry[i] = entries[readIdx[i]];
      rd.flags[i] = flags[readIdx[i]];
    end
  end

endmodule

//--- robReadIf.sv
`timescale 1ns/100ps

// Four sequential read lanes into the ROB storage
// Lane i returns the slot at readBase + i
interface robReadIf;

  robPkg::SqN readBase;
  robPkg::RobEntry entry [robPkg::robWidth];
  uopPkg::RobFlags flags [robPkg::robWidth];

  modport storage (
    input  readBase,
    output entry,
    output flags
  );

  modport reader (
    output readBase,
    input  entry,
    input  flags
  );

endinterface

//--- robPkg.sv
package robPkg;

  // Lanes for enqueue, commit and replay
  localparam int robWidth = 4;
  localparam int idLen = 4;
  localparam int robLength = 1 << idLen;
  localparam int numFlagPorts = 2;
  localparam int regW = 5;
  localparam int tagW = 7;

  // One wrap bit pair above the index so age compares work by subtraction
  localparam int sqNW = idLen + 2;

  typedef logic [idLen-1:0] RobIdx;
  typedef logic [sqNW-1:0] SqN;
  typedef logic [regW-1:0] RegNm;
  typedef logic [tagW-1:0] Tag;

  // Physical tag of the zero register
  localparam Tag tagZero = '0;

  typedef struct packed {
    Tag   tag;
    RegNm rd;
  } RobEntry;

endpackage

//--- uopPkg.sv
package uopPkg;

  // Completion state of a ROB entry
  // Ordered so that range checks classify it
  typedef enum logic [2:0] {
    FLAGS_NONE        = 3'd0,
    FLAGS_BRANCH      = 3'd1,
    FLAGS_FENCE       = 3'd2,
    FLAGS_TRAP        = 3'd3,
    FLAGS_ILLEGAL     = 3'd4,
    FLAGS_LD_MISALIGN = 3'd5,
    FLAGS_NX          = 3'd6
  } RobFlags;

  // How rename classifies an op at enqueue
  typedef enum logic [1:0] {
    KIND_EXEC        = 2'd0,
    KIND_RENAME_ONLY = 2'd1,
    KIND_TRAP        = 2'd2
  } OpKind;

  // Anything from fence up to the exceptions goes to the trap handler
  function automatic logic needsTrap(RobFlags f);
    return (f >= FLAGS_FENCE) && (f < FLAGS_NX);
  endfunction

  function automatic logic isException(RobFlags f);
    return (f == FLAGS_ILLEGAL) || (f == FLAGS_LD_MISALIGN);
  endfunction

endpackage
